//--- hw/agu_consts.svh
// address-path widths, RAM geometry, pipeline latency and command codes
`ifndef AGU_CONSTS_SVH
`define AGU_CONSTS_SVH

// address and register operand widths
`define AGU_ADDR_W 48
`define AGU_REG_W 64
`define AGU_DISP_W 16

// index is extended from this bit upward
`define AGU_IX_SIGN_BIT 32

// carry-select slice width, three slices per address
`define AGU_SLICE_W 16

// bound descriptor limit and the widest window it can open
`define AGU_LIMIT_W 12
`define AGU_WINDOW_W 28

// data RAM geometry, 64-bit words picked by address bits 10..3
`define AGU_RAM_WORDS 256
`define AGU_RAM_AW 8
`define AGU_WORD_LSB 3

// request to response, in cycles
`define AGU_LAT 2

// command encodings
`define AGU_CMD_W 2
`define AGU_CMD_NONE 2'd0
`define AGU_CMD_LOAD 2'd1
`define AGU_CMD_STORE 2'd2
`define AGU_CMD_LEA 2'd3

`endif

//--- hw/aguPkg.sv
// command enum plus request, bound, stage and response structs of the address path
`include "agu_consts.svh"

package aguPkg;

	// what the request asks for
	typedef enum logic [`AGU_CMD_W-1:0]
	{
		cmdNone  = `AGU_CMD_NONE,
		cmdLoad  = `AGU_CMD_LOAD,
		cmdStore = `AGU_CMD_STORE,
		// address only, no RAM access
		cmdLea   = `AGU_CMD_LEA
	} aguCmd_t;

	// index extension field
	typedef struct packed
	{
		// 0..3 is x1, x2, x4, x8
		logic [1:0] scale;
		logic       zeroExt;
		logic       useDisp;
		// keep address bits 47..32
		logic       highEn;
	} aguIxt_t;

	// bounds descriptor
	typedef struct packed
	{
		logic                    checkEn;
		logic                    readOnly;
		// window is limit << (4 * shift + 4)
		logic [1:0]              shift;
		logic [`AGU_LIMIT_W-1:0] limit;
	} aguBound_t;

	// one request as it enters the address stage
	typedef struct packed
	{
		aguCmd_t                cmd;
		aguIxt_t                ixt;
		logic [`AGU_REG_W-1:0]  base;
		logic [`AGU_REG_W-1:0]  index;
		logic [`AGU_DISP_W-1:0] disp;
		aguBound_t              bound;
		logic [`AGU_REG_W-1:0]  storeData;
	} aguReq_t;

	// address stage to access stage
	typedef struct packed
	{
		aguCmd_t                cmd;
		logic [`AGU_ADDR_W-1:0] addr;
		logic                   fault;
		logic [`AGU_REG_W-1:0]  storeData;
	} aguStage_t;

	// what goes back out
	typedef struct packed
	{
		aguCmd_t                cmd;
		logic [`AGU_ADDR_W-1:0] addr;
		logic [`AGU_REG_W-1:0]  data;
		logic                   fault;
	} aguRsp_t;

endpackage

//--- hw/indexScaler.sv
// index extension from bit 32, x1/x2/x4/x8 scaling and displacement select
`include "agu_consts.svh"

module indexScaler
(
	input  logic [`AGU_REG_W-1:0]  index,
	input  logic [`AGU_DISP_W-1:0] disp,
	input  aguPkg::aguIxt_t        ixt,
	output logic [`AGU_ADDR_W-1:0] scaledIndex,
	output logic [`AGU_ADDR_W-1:0] dispExt
);

	// bits above the sign bit, 47..33
	localparam int ExtPad = `AGU_ADDR_W - `AGU_IX_SIGN_BIT - 1;
	localparam int DispPad = `AGU_ADDR_W - `AGU_DISP_W;

	logic                   extBit;
	logic [`AGU_ADDR_W-1:0] extIndex;
	logic [`AGU_ADDR_W-1:0] scaled0;
	logic [`AGU_ADDR_W-1:0] scaled1;
	logic [`AGU_ADDR_W-1:0] scaled2;
	logic [`AGU_ADDR_W-1:0] scaled3;

	always_comb
	begin
		// fill is zero for ZX, a copy of bit 32 for SX
		extBit = ixt.zeroExt ? 1'b0 : index[`AGU_IX_SIGN_BIT];
		extIndex = {{ExtPad{extBit}}, index[`AGU_IX_SIGN_BIT:0]};

		// all four shifts built in parallel
		scaled0 = extIndex;
		scaled1 = {extIndex[`AGU_ADDR_W-2:0], 1'b0};
		scaled2 = {extIndex[`AGU_ADDR_W-3:0], 2'b0};
		scaled3 = {extIndex[`AGU_ADDR_W-4:0], 3'b0};

		// scale just picks one
		case (ixt.scale)
			2'd0: scaledIndex = scaled0;
			2'd1: scaledIndex = scaled1;
			2'd2: scaledIndex = scaled2;
			default: scaledIndex = scaled3;
		endcase

		// displacement is signed, zero when unused
		if (ixt.useDisp)
			dispExt = {{DispPad{disp[`AGU_DISP_W-1]}}, disp};
		else
			dispExt = '0;
	end

endmodule

//--- hw/sliceAdder.sv
// 48-bit base + index + displacement adder built from three 16-bit carry-select slices
`include "agu_consts.svh"

module sliceAdder
(
	input  logic [`AGU_ADDR_W-1:0] base,
	input  logic [`AGU_ADDR_W-1:0] scaledIndex,
	input  logic [`AGU_ADDR_W-1:0] dispExt,
	input  logic                   highEn,
	output logic [`AGU_ADDR_W-1:0] addr
);

	localparam int SW = `AGU_SLICE_W;

	logic [`AGU_ADDR_W-1:0] csaSum;
	logic [`AGU_ADDR_W-1:0] csaMaj;
	logic [`AGU_ADDR_W-1:0] csaCarry;
	logic [SW:0]            lowSum;
	logic [SW:0]            midSum0;
	logic [SW:0]            midSum1;
	logic [SW:0]            midSel;
	logic [SW-1:0]          highSum0;
	logic [SW-1:0]          highSum1;
	logic [SW-1:0]          highPart;

	always_comb
	begin
		// 3:2 compress first, so every slice boundary sees a single carry bit
		// (a sign-extended disp could otherwise push -1 or +2 across a slice)
		csaSum = base ^ scaledIndex ^ dispExt;
		csaMaj = (base & scaledIndex) | (base & dispExt) | (scaledIndex & dispExt);
		csaCarry = {csaMaj[`AGU_ADDR_W-2:0], 1'b0};

		// low slice, carry out in bit 16
		lowSum = {1'b0, csaSum[SW-1:0]} + {1'b0, csaCarry[SW-1:0]};

		// mid slice both ways
		midSum0 = {1'b0, csaSum[2*SW-1:SW]} + {1'b0, csaCarry[2*SW-1:SW]};
		midSum1 = {1'b0, csaSum[2*SW-1:SW]} + {1'b0, csaCarry[2*SW-1:SW]} + 1'b1;
		midSel = lowSum[SW] ? midSum1 : midSum0;

		// top slice both ways, carry out dropped
		highSum0 = csaSum[3*SW-1:2*SW] + csaCarry[3*SW-1:2*SW];
		highSum1 = csaSum[3*SW-1:2*SW] + csaCarry[3*SW-1:2*SW] + 1'b1;

		// top slice held at zero without high-address enable
		highPart = '0;
		if (highEn)
		begin
			highPart = midSel[SW] ? highSum1 : highSum0;
		end

		addr = {highPart, midSel[SW-1:0], lowSum[SW-1:0]};
	end

endmodule

//--- hw/boundsChecker.sv
// bound window decode plus out-of-bounds and read-only store fault decision
`include "agu_consts.svh"

module boundsChecker
(
	input  logic [`AGU_ADDR_W-1:0] scaledIndex,
	input  aguPkg::aguBound_t      bound,
	input  aguPkg::aguCmd_t        cmd,
	output logic                   fault
);

	import aguPkg::*;

	logic [`AGU_WINDOW_W-1:0] window;
	logic                     upperSet;
	logic                     lowAtOrAbove;
	logic                     idxNeg;
	logic                     idxAbove;
	logic                     roStore;

	// limit scaled by 16, 256, 4K or 64K
	always_comb
	begin
		case (bound.shift)
			2'd0:
			begin
				window = {12'h000, bound.limit, 4'h0};
			end
			2'd1:
			begin
				window = {8'h00, bound.limit, 8'h00};
			end
			2'd2:
			begin
				window = {4'h0, bound.limit, 12'h000};
			end
			default:
			begin
				window = {bound.limit, 16'h0000};
			end
		endcase
	end

	always_comb
	begin
		// anything above bit 27 is past every window
		upperSet = |scaledIndex[`AGU_ADDR_W-1:`AGU_WINDOW_W];
		lowAtOrAbove = scaledIndex[`AGU_WINDOW_W-1:0] >= window;
		// unsigned compare, split at the window width
		idxAbove = upperSet || lowAtOrAbove;

		// negative index checked on its own
		idxNeg = scaledIndex[`AGU_ADDR_W-1];

		// no writes through a const descriptor
		roStore = bound.readOnly && (cmd == cmdStore);

		// nothing faults without checkEn
		fault = bound.checkEn && (idxNeg || idxAbove || roStore);
	end

endmodule

//--- hw/addressGenUnit.sv
// address stage with index scaler, slice adder and bounds check ahead of one register
`include "agu_consts.svh"

module addressGenUnit
(
	input  logic              clock,
	input  logic              reset,
	input  logic              reqValid,
	input  aguPkg::aguReq_t   req,
	output logic              stageValid,
	output aguPkg::aguStage_t stage
);

	import aguPkg::*;

	logic [`AGU_ADDR_W-1:0] scaledIndex;
	logic [`AGU_ADDR_W-1:0] dispExt;
	logic [`AGU_ADDR_W-1:0] addr;
	logic                   fault;
	aguStage_t              nextStage;

	indexScaler u_indexScaler
	(
		.index       (req.index),
		.disp        (req.disp),
		.ixt         (req.ixt),
		.scaledIndex (scaledIndex),
		.dispExt     (dispExt)
	);

	// only the low 48 bits of base matter
	sliceAdder u_sliceAdder
	(
		.base        (req.base[`AGU_ADDR_W-1:0]),
		.scaledIndex (scaledIndex),
		.dispExt     (dispExt),
		.highEn      (req.ixt.highEn),
		.addr        (addr)
	);

	// bound check sees the scaled index, not the sum
	boundsChecker u_boundsChecker
	(
		.scaledIndex (scaledIndex),
		.bound       (req.bound),
		.cmd         (req.cmd),
		.fault       (fault)
	);

	always_comb
	begin
		nextStage.cmd = req.cmd;
		nextStage.addr = addr;
		nextStage.fault = fault;
		nextStage.storeData = req.storeData;
	end

	// strobe follows the request by one cycle
	always_ff @(posedge clock)
	begin
		if (reset)
			stageValid <= 1'b0;
		else
			stageValid <= reqValid;
	end

	// payload only moves with a request
	always_ff @(posedge clock)
	begin
		if (reqValid)
			stage <= nextStage;
	end

endmodule

//--- hw/dataAccessStage.sv
// data RAM stage doing loads and stores and forming the response
`include "agu_consts.svh"

module dataAccessStage
(
	input  logic              clock,
	input  logic              reset,
	input  logic              stageValid,
	input  aguPkg::aguStage_t stage,
	output logic              rspValid,
	output aguPkg::aguRsp_t   rsp
);

	import aguPkg::*;

	// 256 x 64 word RAM, contents undefined until written
	logic [`AGU_REG_W-1:0]  ram [`AGU_RAM_WORDS];
	logic [`AGU_RAM_AW-1:0] wordIdx;
	logic                   accessOk;
	logic                   doWrite;
	logic                   doRead;

	always_comb
	begin
		// byte address to word index, bits 10..3
		wordIdx = stage.addr[`AGU_WORD_LSB +: `AGU_RAM_AW];
		// faulted requests never reach the array
		accessOk = stageValid && !stage.fault;
		doWrite = accessOk && (stage.cmd == cmdStore);
		doRead = accessOk && (stage.cmd == cmdLoad);
	end

	// write port
	always_ff @(posedge clock)
	begin
		if (doWrite)
			ram[wordIdx] <= stage.storeData;
	end

	// response strobe, one cycle after the stage
	always_ff @(posedge clock)
	begin
		if (reset)
			rspValid <= 1'b0;
		else
			rspValid <= stageValid;
	end

	// registered read; store, lea and faults give zero data
	always_ff @(posedge clock)
	begin
		if (stageValid)
		begin
			rsp.cmd <= stage.cmd;
			rsp.addr <= stage.addr;
			rsp.fault <= stage.fault;
			if (doRead)
				rsp.data <= ram[wordIdx];
			else
				rsp.data <= '0;
		end
	end

endmodule

//--- hw/loadStorePath.sv
// load/store path top with the address stage feeding the RAM access stage
module loadStorePath
(
	input  logic            clock,
	input  logic            reset,
	input  logic            reqValid,
	input  aguPkg::aguReq_t req,
	output logic            rspValid,
	output aguPkg::aguRsp_t rsp
);

	import aguPkg::*;

	// between the two stages
	logic      stageValid;
	aguStage_t stage;

	// cycle 1, address and fault
	addressGenUnit u_addressGenUnit
	(
		.clock      (clock),
		.reset      (reset),
		.reqValid   (reqValid),
		.req        (req),
		.stageValid (stageValid),
		.stage      (stage)
	);

	// cycle 2, RAM access and response
	dataAccessStage u_dataAccessStage
	(
		.clock      (clock),
		.reset      (reset),
		.stageValid (stageValid),
		.stage      (stage),
		.rspValid   (rspValid),
		.rsp        (rsp)
	);

endmodule

//--- bench/loadStoreBench.sv
// testbench for loadStorePath with trace replay, random lea requests and response checks
`include "agu_consts.svh"

module loadStoreBench;

	import aguPkg::*;

	// one replayed trace line
	typedef struct packed
	{
		logic [7:0] test;
		logic       valid;
		aguReq_t    req;
		aguRsp_t    exp;
	} traceLine_t;

	// a response the DUT still owes
	typedef struct packed
	{
		logic [7:0]  test;
		logic [31:0] due;
		aguRsp_t     exp;
	} pending_t;

	logic       clock = 1'b0;
	logic       reset;
	logic       reqValid;
	aguReq_t    req;
	logic       rspValid;
	aguRsp_t    rsp;

	traceLine_t lines[$];
	pending_t   expQ[$];
	pending_t   head;
	int         testErr[16];
	int         testEnd[16];
	int         cycle = 0;
	int         limit;
	int         errCount = 0;
	int         passCount = 0;
	int         nextReport = 1;
	int         stimTest = 0;
	int         lastTest = 0;
	int         seed = 32'h4e61;

	loadStorePath u_loadStorePath
	(
		.clock    (clock),
		.reset    (reset),
		.reqValid (reqValid),
		.req      (req),
		.rspValid (rspValid),
		.rsp      (rsp)
	);

	// 20 unit period
	always #10 clock = ~clock;

	task automatic noteError(input int test);
		errCount++;
		testErr[test]++;
	endtask

	task automatic compareField(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal, input int test);
		assert (actVal === expVal)
		else
		begin
			$display("Error: time %0t, %s expected %h, got %h", $time, name, expVal, actVal);
			noteError(test);
		end
	endtask

	// address rule written out plainly with full-width adds
	function automatic logic [47:0] refAddr(input aguReq_t r);
		logic [47:0] ext;
		logic [47:0] sum;
		ext = {{15{r.index[32] & ~r.ixt.zeroExt}}, r.index[32:0]};
		sum = r.base[47:0] + (ext << r.ixt.scale);
		if (r.ixt.useDisp)
			sum = sum + {{32{r.disp[15]}}, r.disp};
		if (!r.ixt.highEn)
			sum[47:32] = '0;
		return sum;
	endfunction

	task automatic loadTrace();
		int          fd;
		int          n;
		string       text;
		logic [63:0] f [13];
		traceLine_t  rec;
		fd = $fopen("bench/agu_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open bench/agu_trace.txt");
			noteError(0);
			return;
		end
		while ($fgets(text, fd) != 0)
		begin
			// comment lines scan as nothing
			n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
				f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
			if (n == 13)
			begin
				rec.test = f[0][7:0];
				rec.valid = f[1][0];
				rec.req.cmd = aguCmd_t'(f[2][1:0]);
				rec.req.ixt = f[3][4:0];
				rec.req.base = f[4];
				rec.req.index = f[5];
				rec.req.disp = f[6][15:0];
				rec.req.bound = f[7][15:0];
				rec.req.storeData = f[8];
				rec.exp.cmd = aguCmd_t'(f[9][1:0]);
				rec.exp.addr = f[10][47:0];
				rec.exp.data = f[11];
				rec.exp.fault = f[12][0];
				lines.push_back(rec);
			end
			else if (n > 0)
			begin
				$display("malformed trace line: %s", text);
				noteError(0);
			end
		end
		$fclose(fd);
	endtask

	// random lea requests with checkEn low give no fault and zero data
	task automatic addRandomLeas(input int test, input int count);
		traceLine_t rec;
		int         k;
		for (k = 0; k < count; k++)
		begin
			rec = '0;
			rec.test = test;
			rec.valid = 1'b1;
			rec.req.cmd = cmdLea;
			rec.req.ixt = 5'($random(seed));
			rec.req.base = {$random(seed), $random(seed)};
			rec.req.index = {$random(seed), $random(seed)};
			rec.req.disp = 16'($random(seed));
			rec.req.bound = {1'b0, 15'($random(seed))};
			rec.exp.cmd = cmdLea;
			rec.exp.addr = refAddr(rec.req);
			lines.push_back(rec);
		end
	endtask

	// stimulus and final report
	initial
	begin
		pending_t item;
		reset = 1'b1;
		reqValid = 1'b0;
		req = '0;
		loadTrace();
		if (lines.size() > 0)
			lastTest = lines[lines.size() - 1].test;
		lastTest++;
		addRandomLeas(lastTest, 8);
		// one cycle per line plus reset, latency and slack
		limit = lines.size() + 3 + `AGU_LAT + 10;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		foreach (lines[i])
		begin
			@(posedge clock);
			reqValid <= lines[i].valid;
			req <= lines[i].req;
			stimTest = lines[i].test;
			// sampled on the next edge and answered LAT edges later
			testEnd[lines[i].test] = cycle + `AGU_LAT + 1;
			if (lines[i].valid)
			begin
				item.test = lines[i].test;
				item.due = cycle + `AGU_LAT + 1;
				item.exp = lines[i].exp;
				expQ.push_back(item);
			end
		end
		@(posedge clock);
		reqValid <= 1'b0;
		req <= '0;
		stimTest = 16;
		while (nextReport <= lastTest)
			@(posedge clock);
		repeat (2) @(posedge clock);
		if (expQ.size() > 0)
		begin
			$display("%0d requests never got a response", expQ.size());
			noteError(0);
		end
		$display("tests passed: %0d of %0d, errors: %0d", passCount, lastTest, errCount);
		if (errCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// responses checked mid-cycle away from the edge
	always @(negedge clock)
	begin
		cycle = cycle + 1;
		if (reset)
		begin
			assert (rspValid === 1'b0)
			else
			begin
				$display("Error: time %0t, rspValid expected 0, got %b", $time, rspValid);
				noteError(0);
			end
		end
		else if (rspValid === 1'b1)
		begin
			if (expQ.size() > 0 && expQ[0].due == cycle)
			begin
				head = expQ.pop_front();
				compareField("rsp.cmd", head.exp.cmd, rsp.cmd, head.test);
				compareField("rsp.addr", head.exp.addr, rsp.addr, head.test);
				compareField("rsp.data", head.exp.data, rsp.data, head.test);
				compareField("rsp.fault", head.exp.fault, rsp.fault, head.test);
			end
			else
			begin
				$display("response at cycle %0d has no matching request", cycle);
				noteError(nextReport);
			end
		end
		else if (expQ.size() > 0 && expQ[0].due <= cycle)
		begin
			head = expQ.pop_front();
			$display("request of test %0d got no response by cycle %0d", head.test, cycle);
			noteError(head.test);
		end
		// test over once its last response was due
		if (nextReport < stimTest && cycle >= testEnd[nextReport])
		begin
			if (testErr[nextReport] == 0)
			begin
				$display("test %0d passed", nextReport);
				passCount++;
			end
			else
				$display("test %0d failed with %0d errors", nextReport, testErr[nextReport]);
			nextReport++;
		end
	end

	// watchdog
	always @(posedge clock)
	begin
		if (cycle > limit)
		begin
			$display("timeout after %0d cycles with responses still outstanding", cycle);
			$display("Done: errors found");
			$finish;
		end
	end

endmodule

//--- list.f
+incdir+hw
hw/aguPkg.sv
hw/indexScaler.sv
hw/sliceAdder.sv
hw/boundsChecker.sv
hw/addressGenUnit.sv
hw/dataAccessStage.sv
hw/loadStorePath.sv
bench/loadStoreBench.sv

//--- Bender.yml
package:
  name: load_store_path

export_include_dirs:
  - hw

sources:
  - files:
      - hw/aguPkg.sv
      - hw/indexScaler.sv
      - hw/sliceAdder.sv
      - hw/boundsChecker.sv
      - hw/addressGenUnit.sv
      - hw/dataAccessStage.sv
      - hw/loadStorePath.sv
  - target: simulation
    files:
      - bench/loadStoreBench.sv

//--- bench/agu_trace.txt
// test valid cmd ixt base index disp bound storeData, then expected cmd addr data fault
// all hex; ixt = {scale[4:3], zeroExt, useDisp, highEn}, bound = {checkEn, readOnly, shift, limit}
1 1 3 01 1000 20 0 0 0 3 1020 0 0
1 1 3 0f 1000 100000010 10 0 0 3 200001030 0 0
1 1 3 13 400001000 100000010 fff0 0 0 3 1030 0 0
1 1 3 18 555500002000 fffffffe00000008 0 0 0 3 2040 0 0
1 1 3 07 2000 180000000 8000 0 0 3 17fffa000 0 0
2 1 3 01 ffffffff 1 0 0 0 3 100000000 0 0
2 1 3 00 ffffffff 1 0 0 0 3 0 0 0
2 1 3 01 7fffffffffff 3 0 0 0 3 800000000002 0 0
2 1 3 00 7fffffffffff 3 0 0 0 3 2 0 0
2 1 3 03 300000000 0 ffff 0 0 3 2ffffffff 0 0
2 1 3 02 300000000 0 ffff 0 0 3 ffffffff 0 0
3 1 2 01 40 0 0 0 1122334455667788 2 40 0 0
3 1 1 01 40 0 0 0 0 1 40 1122334455667788 0
3 1 2 19 700 1f 0 0 deadbeefcafef00d 2 7f8 0 0
3 1 1 19 1700 1f 0 0 0 1 17f8 deadbeefcafef00d 0
4 1 3 01 0 ff 0 8010 0 3 ff 0 0
4 1 3 01 0 100 0 8010 0 3 100 0 1
4 1 3 01 0 fff 0 9010 0 3 fff 0 0
4 1 3 01 0 1000 0 9010 0 3 1000 0 1
4 1 3 01 0 ffff 0 a010 0 3 ffff 0 0
4 1 3 01 0 10000 0 a010 0 3 10000 0 1
4 1 3 01 0 ffeffff 0 bfff 0 3 ffeffff 0 0
4 1 3 01 0 fff0000 0 bfff 0 3 fff0000 0 1
4 1 3 01 0 100000000 0 bfff 0 3 ffff00000000 0 1
4 1 3 01 0 100 0 0010 0 3 100 0 0
5 1 2 01 80 0 0 0 0123456789abcdef 2 80 0 0
5 1 2 01 80 0 0 ffff 5555aaaa5555aaaa 2 80 0 1
5 1 1 01 80 0 0 ffff 0 1 80 0123456789abcdef 0
6 0 0 00 0 0 0 0 0 0 0 0 0
6 0 2 01 80 0 0 0 ffffffffffffffff 0 0 0 0
6 0 0 00 0 0 0 0 0 0 0 0 0
6 1 1 01 80 0 0 0 0 1 80 0123456789abcdef 0
